/* list.f */
+incdir+tests
logic/ahb_pkg.sv
logic/sram_pkg.sv
logic/ram_1r1w.sv
logic/ahb_sram.sv
logic/ahb_decoder.sv
logic/sram_subsystem.sv
tests/tb_sram_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SRAM subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_sram_subsystem \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

/* tests/tb_ahb_tasks.svh */
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Address phase, driven a short delay after the rising edge
task automatic drive_addr(
  input logic             write,
  input ahb_pkg::haddr_t  addr,
  input ahb_pkg::hsize_t  size,
  input ahb_pkg::htrans_t trans
);
  #2;
  hsel   = 1'b1;
  haddr  = addr;
  hwrite = write;
  hsize  = size;
  htrans = trans;
  // Non-transfer cycles must see a zero-wait OKAY
  idle_check = (trans == ahb_pkg::IDLE) || (trans == ahb_pkg::BUSY);
endtask

// Returns just after the first rising edge with HREADY high
// HREADY is looked at on the falling edge where it is stable
task automatic wait_ready;
  logic rdy;
  rdy = 1'b0;
  while (!rdy) begin
    @(negedge HCLK);
    rdy = hready;
    @(posedge HCLK);
  end
endtask

// Data phase of the last accepted transfer
// Bus goes IDLE with the address held, as the SRAM read port expects
task automatic finish_data(input ahb_pkg::hdata_t wdata);
  #2;
  htrans = ahb_pkg::IDLE;
  hwdata = wdata;
  wait_ready();
endtask

`endif

/* tests/tb_sram_subsystem.sv */
`timescale 1ns/1ns

module tb_sram_subsystem;

  localparam int BANK_DEPTH     = 16;
  localparam int MAP_BYTES      = 2 * sram_pkg::BYTE_LANES * BANK_DEPTH;
  localparam int MAP_WORDS      = MAP_BYTES / sram_pkg::BYTE_LANES;
  localparam int BANK1_BASE     = MAP_BYTES / 2;
  localparam int PERIOD_NS      = 40;
  // Upper bound on transfers issued by all tests
  localparam int TRANSFER_COUNT = 120;
  localparam int WATCHDOG_NS    = (TRANSFER_COUNT * 4 + 40) * PERIOD_NS;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic             HCLK;
  logic             HRESETn;
  logic             hsel;
  ahb_pkg::haddr_t  haddr;
  ahb_pkg::hdata_t  hwdata;
  logic             hwrite;
  ahb_pkg::hsize_t  hsize;
  logic [2:0]       hburst;
  logic [3:0]       hprot;
  ahb_pkg::htrans_t htrans;
  logic             hmastlock;
  ahb_pkg::hdata_t  hrdata;
  logic             hready;
  ahb_pkg::hresp_t  hresp;

  // Expectation for the next address phase
  logic             nx_check;
  ahb_pkg::hdata_t  nx_exp;
  int               nx_waits;
  ahb_pkg::hresp_t  nx_resp;
  // Expectation for the transfer now in its data phase
  logic             dp_valid;
  logic             dp_check;
  ahb_pkg::hdata_t  dp_exp;
  int               dp_waits;
  ahb_pkg::hresp_t  dp_resp;
  int               wait_cnt;
  logic             idle_check;

  // Byte-wide reference memory over both banks
  logic [7:0]       model [MAP_BYTES];
  logic [31:0]      rng;
  string            test_name;
  int               fail_cnt;
  int               test_errs;
  int               tests_run;
  int               failed_tests;

  `include "tb_ahb_tasks.svh"

  // Only slave on the bus, so HREADY is its own HREADYOUT
  sram_subsystem #(
    .BANK_DEPTH (BANK_DEPTH)
  ) dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (hsel),
    .HADDR     (haddr),
    .HWDATA    (hwdata),
    .HWRITE    (hwrite),
    .HSIZE     (hsize),
    .HBURST    (hburst),
    .HPROT     (hprot),
    .HTRANS    (htrans),
    .HMASTLOCK (hmastlock),
    .HREADY    (hready),
    .HRDATA    (hrdata),
    .HREADYOUT (hready),
    .HRESP     (hresp)
  );

  initial begin
    HCLK = 1'b0;
    forever #(PERIOD_NS / 2) HCLK = ~HCLK;
  end

  // Bus-side view of the data phase and its wait states
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_valid <= 1'b0;
      dp_check <= 1'b0;
      dp_exp   <= '0;
      dp_waits <= 0;
      dp_resp  <= ahb_pkg::HRESP_OKAY;
      wait_cnt <= 0;
    end else if (hready) begin
      dp_valid <= hsel && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);
      dp_check <= nx_check;
      dp_exp   <= nx_exp;
      dp_waits <= nx_waits;
      dp_resp  <= nx_resp;
      wait_cnt <= 0;
    end else begin
      wait_cnt <= wait_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_read_data : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (dp_valid && dp_check && hready) |-> (hrdata == dp_exp)
  ) else begin
    fail_cnt++;
    $display("error %s: HRDATA expected %h actual %h",
             test_name, $sampled(dp_exp), $sampled(hrdata));
  end

  a_wait_states : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (dp_valid && hready) |-> (wait_cnt == dp_waits)
  ) else begin
    fail_cnt++;
    $display("error %s: wait states expected %0d actual %0d",
             test_name, $sampled(dp_waits), $sampled(wait_cnt));
  end

  // Every data-phase cycle, the ERROR pair included
  a_response : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    dp_valid |-> (hresp == dp_resp)
  ) else begin
    fail_cnt++;
    $display("error %s: HRESP expected %0d actual %0d",
             test_name, $sampled(dp_resp), $sampled(hresp));
  end

  a_idle_okay : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    idle_check |-> (hready && hresp == ahb_pkg::HRESP_OKAY)
  ) else begin
    fail_cnt++;
    $display("error %s: expected HREADYOUT 1 HRESP 0 actual HREADYOUT %b HRESP %b",
             test_name, $sampled(hready), $sampled(hresp));
  end

  ////////////////////////////////////////
  // Reference model and transfers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Each byte goes to the lane picked by its own address
  task automatic model_write(ahb_pkg::haddr_t addr, ahb_pkg::hsize_t size,
                             ahb_pkg::hdata_t data);
    int a;
    for (int i = 0; i < (1 << int'(size)); i++) begin
      a = int'(addr) + i;
      model[a] = data[8 * (a % 4) +: 8];
    end
  endtask

  function automatic ahb_pkg::hdata_t model_word(ahb_pkg::haddr_t addr);
    int a;
    a = int'(addr);
    return {model[a + 3], model[a + 2], model[a + 1], model[a]};
  endfunction

  task automatic set_expect(logic check, ahb_pkg::hdata_t exp, int waits,
                            ahb_pkg::hresp_t resp);
    nx_check = check;
    nx_exp   = exp;
    nx_waits = waits;
    nx_resp  = resp;
  endtask

  task automatic do_write(ahb_pkg::haddr_t addr, ahb_pkg::hsize_t size,
                          ahb_pkg::hdata_t data);
    model_write(addr, size, data);
    drive_addr(1'b1, addr, size, ahb_pkg::NONSEQ);
    set_expect(1'b0, '0, 0, ahb_pkg::HRESP_OKAY);
    wait_ready();
    finish_data(data);
  endtask

  task automatic do_read(ahb_pkg::haddr_t addr);
    drive_addr(1'b0, addr, ahb_pkg::HSIZE_WORD, ahb_pkg::NONSEQ);
    set_expect(1'b1, model_word(addr), 0, ahb_pkg::HRESP_OKAY);
    wait_ready();
    finish_data('0);
  endtask

  // Read address phase overlaps the write data phase
  task automatic write_then_read(ahb_pkg::haddr_t waddr, ahb_pkg::hsize_t size,
                                 ahb_pkg::hdata_t data, ahb_pkg::haddr_t raddr,
                                 int waits);
    model_write(waddr, size, data);
    drive_addr(1'b1, waddr, size, ahb_pkg::NONSEQ);
    set_expect(1'b0, '0, 0, ahb_pkg::HRESP_OKAY);
    wait_ready();
    drive_addr(1'b0, raddr, ahb_pkg::HSIZE_WORD, ahb_pkg::NONSEQ);
    hwdata = data;
    set_expect(1'b1, model_word(raddr), waits, ahb_pkg::HRESP_OKAY);
    wait_ready();
    finish_data('0);
  endtask

  // Default slave answers with one wait then ERROR
  task automatic unmapped_access(logic write, ahb_pkg::haddr_t addr);
    drive_addr(write, addr, ahb_pkg::HSIZE_WORD, ahb_pkg::NONSEQ);
    set_expect(1'b0, '0, 1, ahb_pkg::HRESP_ERROR);
    wait_ready();
    finish_data(next_random());
  endtask

  // IDLE or BUSY with a write look, nothing may land
  task automatic idle_cycles(ahb_pkg::htrans_t trans, ahb_pkg::haddr_t addr, int n);
    drive_addr(1'b1, addr, ahb_pkg::HSIZE_WORD, trans);
    hwdata = next_random();
    set_expect(1'b0, '0, 0, ahb_pkg::HRESP_OKAY);
    repeat (n) @(posedge HCLK);
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errs = fail_cnt;
  endtask

  task automatic end_test;
    #1;
    tests_run++;
    if (fail_cnt == test_errs) begin
      $display("test %s: ok", test_name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", test_name, fail_cnt - test_errs);
    end
    @(posedge HCLK);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int wa;
    HRESETn      = 1'b0;
    hsel         = 1'b0;
    haddr        = '0;
    hwdata       = '0;
    hwrite       = 1'b0;
    hsize        = ahb_pkg::HSIZE_WORD;
    hburst       = '0;
    hprot        = '0;
    htrans       = ahb_pkg::IDLE;
    hmastlock    = 1'b0;
    idle_check   = 1'b0;
    rng          = 32'h3d0f9975;
    fail_cnt     = 0;
    test_errs    = 0;
    tests_run    = 0;
    failed_tests = 0;
    set_expect(1'b0, '0, 0, ahb_pkg::HRESP_OKAY);
    repeat (4) @(posedge HCLK);
    #2;
    HRESETn    = 1'b1;
    idle_check = 1'b1;

    start_test("after_reset");
    repeat (3) @(posedge HCLK);
    end_test();

    // Fill every word of both banks, then read all back
    start_test("word_rw");
    for (int w = 0; w < MAP_WORDS; w++) begin
      do_write(w * 4, ahb_pkg::HSIZE_WORD, next_random());
    end
    for (int w = 0; w < MAP_WORDS; w++) begin
      do_read(w * 4);
    end
    end_test();

    // Bytes at all four lanes, halfwords at both halves
    start_test("byte_merge");
    for (int k = 0; k < 4; k++) begin
      wa = int'(next_random() % MAP_WORDS) * 4;
      for (int off = 0; off < 4; off++) begin
        do_write(wa + off, ahb_pkg::HSIZE_BYTE, next_random());
      end
      do_read(wa);
      do_write(wa, ahb_pkg::HSIZE_HWORD, next_random());
      do_read(wa);
      do_write(wa + 2, ahb_pkg::HSIZE_HWORD, next_random());
      do_read(wa);
    end
    end_test();

    // Partial write stalls once, full write is forwarded
    start_test("stall_fwd");
    wa = 20;
    write_then_read(wa + 1, ahb_pkg::HSIZE_BYTE, next_random(), wa, 1);
    write_then_read(wa + 2, ahb_pkg::HSIZE_HWORD, next_random(), wa, 1);
    write_then_read(wa, ahb_pkg::HSIZE_WORD, next_random(), wa, 0);
    // Same word index in the other bank, no contention
    write_then_read(BANK1_BASE + wa + 3, ahb_pkg::HSIZE_BYTE, next_random(), wa, 0);
    end_test();

    start_test("unmapped");
    unmapped_access(1'b1, MAP_BYTES);
    unmapped_access(1'b0, 32'h0000_1000);
    do_read(0);
    do_read(BANK1_BASE);
    end_test();

    start_test("no_transfer");
    idle_cycles(ahb_pkg::IDLE, 8, 2);
    idle_cycles(ahb_pkg::BUSY, BANK1_BASE + 8, 2);
    idle_cycles(ahb_pkg::IDLE, MAP_BYTES + 8, 1);
    do_read(8);
    do_read(BANK1_BASE + 8);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, fail_cnt);
    if (fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Hung handshake guard
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: HREADY never completed the tests within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* logic/sram_subsystem.sv */
`timescale 1ns/1ns

module sram_subsystem #(
  parameter int BANK_DEPTH = 256
) (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             HSEL,
  input  ahb_pkg::haddr_t  HADDR,
  input  ahb_pkg::hdata_t  HWDATA,
  input  logic             HWRITE,
  input  ahb_pkg::hsize_t  HSIZE,
  // Burst, protection and lock are accepted and not used
  input  logic [2:0]       HBURST,
  input  logic [3:0]       HPROT,
  input  ahb_pkg::htrans_t HTRANS,
  input  logic             HMASTLOCK,
  input  logic             HREADY,
  output ahb_pkg::hdata_t  HRDATA,
  output logic             HREADYOUT,
  output ahb_pkg::hresp_t  HRESP
);

  ////////////////////////////////////////
  // Bank response wires
  ////////////////////////////////////////

  logic            sel_bank0;
  logic            sel_bank1;
  ahb_pkg::hdata_t hrdata0;
  ahb_pkg::hdata_t hrdata1;
  logic            hreadyout0;
  logic            hreadyout1;
  ahb_pkg::hresp_t hresp0;
  ahb_pkg::hresp_t hresp1;

  ahb_decoder #(
    .BANK_DEPTH (BANK_DEPTH)
  ) u_decoder (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HSEL       (HSEL),
    .HADDR      (HADDR),
    .HTRANS     (HTRANS),
    .HREADY     (HREADY),
    .sel_bank0  (sel_bank0),
    .sel_bank1  (sel_bank1),
    .hrdata0    (hrdata0),
    .hreadyout0 (hreadyout0),
    .hresp0     (hresp0),
    .hrdata1    (hrdata1),
    .hreadyout1 (hreadyout1),
    .hresp1     (hresp1),
    .HRDATA     (HRDATA),
    .HREADYOUT  (HREADYOUT),
    .HRESP      (HRESP)
  );

  // Low bank at byte address 0
  ahb_sram #(
    .BANK_DEPTH (BANK_DEPTH)
  ) u_bank0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (sel_bank0),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HRDATA    (hrdata0),
    .HREADYOUT (hreadyout0),
    .HRESP     (hresp0)
  );

  // High bank, upper address bits are dropped by the word slice
  ahb_sram #(
    .BANK_DEPTH (BANK_DEPTH)
  ) u_bank1 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (sel_bank1),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HRDATA    (hrdata1),
    .HREADYOUT (hreadyout1),
    .HRESP     (hresp1)
  );

endmodule

/* logic/ahb_decoder.sv */
`timescale 1ns/1ns

module ahb_decoder #(
  parameter int BANK_DEPTH = 256
) (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             HSEL,
  input  ahb_pkg::haddr_t  HADDR,
  input  ahb_pkg::htrans_t HTRANS,
  input  logic             HREADY,
  output logic             sel_bank0,
  output logic             sel_bank1,
  input  ahb_pkg::hdata_t  hrdata0,
  input  logic             hreadyout0,
  input  ahb_pkg::hresp_t  hresp0,
  input  ahb_pkg::hdata_t  hrdata1,
  input  logic             hreadyout1,
  input  ahb_pkg::hresp_t  hresp1,
  output ahb_pkg::hdata_t  HRDATA,
  output logic             HREADYOUT,
  output ahb_pkg::hresp_t  HRESP
);

  // Bytes per bank, bank 1 starts right after bank 0
  localparam int BANK_BYTES = sram_pkg::BYTE_LANES * BANK_DEPTH;

  logic                  hit0;
  logic                  hit1;
  logic                  sel_dflt;
  logic                  own0;
  logic                  own1;
  sram_pkg::dflt_state_t dflt_state;
  logic                  dflt_ready;
  ahb_pkg::hresp_t       dflt_resp;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign hit0      = HADDR < ahb_pkg::haddr_t'(BANK_BYTES);
  assign hit1      = (HADDR >= ahb_pkg::haddr_t'(BANK_BYTES)) &&
                     (HADDR < ahb_pkg::haddr_t'(2 * BANK_BYTES));
  assign sel_bank0 = HSEL && hit0;
  assign sel_bank1 = HSEL && hit1;
  assign sel_dflt  = HSEL && !hit0 && !hit1;

  // Owner of the data phase, none after reset
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      own0 <= 1'b0;
      own1 <= 1'b0;
    end else if (HREADY) begin
      own0 <= sel_bank0;
      own1 <= sel_bank1;
    end
  end

  ////////////////////////////////////////
  // Default slave
  ////////////////////////////////////////

  // Two-cycle ERROR for unmapped transfers
  // IDLE and BUSY fall through with a zero-wait OKAY
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dflt_state <= sram_pkg::DFLT_IDLE;
      dflt_ready <= 1'b1;
      dflt_resp  <= ahb_pkg::HRESP_OKAY;
    end else begin
      case (dflt_state)
        sram_pkg::DFLT_ERR2: begin
          // Second cycle, release the bus but keep ERROR
          dflt_state <= sram_pkg::DFLT_IDLE;
          dflt_ready <= 1'b1;
          dflt_resp  <= ahb_pkg::HRESP_ERROR;
        end
        default: begin
          if (HREADY && sel_dflt &&
              (HTRANS == ahb_pkg::NONSEQ || HTRANS == ahb_pkg::SEQ)) begin
            dflt_state <= sram_pkg::DFLT_ERR2;
            dflt_ready <= 1'b0;
            dflt_resp  <= ahb_pkg::HRESP_ERROR;
          end else begin
            dflt_ready <= 1'b1;
            dflt_resp  <= ahb_pkg::HRESP_OKAY;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////

  always_comb begin
    if (own0) begin
      HRDATA    = hrdata0;
      HREADYOUT = hreadyout0;
      HRESP     = hresp0;
    end else if (own1) begin
      HRDATA    = hrdata1;
      HREADYOUT = hreadyout1;
      HRESP     = hresp1;
    end else begin
      HRDATA    = '0;
      HREADYOUT = dflt_ready;
      HRESP     = dflt_resp;
    end
  end

  // Banks must not overlap in the map
  a_one_bank : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $onehot0({sel_bank0, sel_bank1})
  );

endmodule

/* logic/ahb_sram.sv */
`timescale 1ns/1ns

module ahb_sram #(
  parameter int BANK_DEPTH = 256
) (
  input  logic             HCLK,
  input  logic             HRESETn,
  input  logic             HSEL,
  input  ahb_pkg::haddr_t  HADDR,
  input  ahb_pkg::hdata_t  HWDATA,
  input  logic             HWRITE,
  input  ahb_pkg::hsize_t  HSIZE,
  input  ahb_pkg::htrans_t HTRANS,
  input  logic             HREADY,
  output ahb_pkg::hdata_t  HRDATA,
  output logic             HREADYOUT,
  output ahb_pkg::hresp_t  HRESP
);

  // Word address width of this bank
  localparam int ABITS = $clog2(BANK_DEPTH);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic               trans_valid;
  logic               we;
  sram_pkg::byte_en_t be;
  logic [ABITS-1:0]   waddr;
  logic [ABITS-1:0]   raddr;
  logic               contention;
  logic               ready;
  ahb_pkg::hdata_t    dout;

  ////////////////////////////////////////
  // Byte-enable decode
  ////////////////////////////////////////

  // Lanes touched by a transfer of this size at this byte offset
  function automatic sram_pkg::byte_en_t gen_be(
    input ahb_pkg::hsize_t                  hsize,
    input logic [sram_pkg::LANE_BITS-1:0]   offset
  );
    sram_pkg::byte_en_t lanes;
    case (hsize)
      ahb_pkg::HSIZE_WORD:  lanes = 4'b1111;
      ahb_pkg::HSIZE_HWORD: lanes = 4'b0011;
      default:              lanes = 4'b0001;
    endcase
    return lanes << offset;
  endfunction

  // NONSEQ and SEQ carry data, IDLE and BUSY do not
  assign trans_valid = (HTRANS == ahb_pkg::NONSEQ) || (HTRANS == ahb_pkg::SEQ);

  // Word address of the live address phase
  assign raddr = HADDR[sram_pkg::LANE_BITS +: ABITS];

  ////////////////////////////////////////
  // Address-phase capture
  ////////////////////////////////////////

  // Write strobe for the data phase
  // Cleared while the bus is stalled so a held write lands only once
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we <= 1'b0;
    end else if (HREADY) begin
      we <= HSEL & HWRITE & trans_valid;
    end else begin
      we <= 1'b0;
    end
  end

  // Lanes and word address of the pending write
  always_ff @(posedge HCLK) begin
    if (HREADY) begin
      be    <= gen_be(HSIZE, HADDR[sram_pkg::LANE_BITS-1:0]);
      waddr <= raddr;
    end
  end

  ////////////////////////////////////////
  // Contention stall
  ////////////////////////////////////////

  // Read accepted now while the write to the same word is in its data phase
  assign contention = we && (waddr == raddr) &&
                      HSEL && HREADY && !HWRITE && trans_valid;

  // Full-word writes are forwarded by the RAM
  // partial writes need one more cycle for the merged word
  assign ready = !(contention && !(&be));

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      HREADYOUT <= 1'b1;
    end else begin
      HREADYOUT <= ready;
    end
  end

  ////////////////////////////////////////
  // Memory
  ////////////////////////////////////////

  // Write lands one cycle after the address phase
  // read is started from the live address
  ram_1r1w #(
    .ABITS   (ABITS)
  ) u_ram (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .waddr   (waddr),
    .we      (we),
    .be      (be),
    .din     (HWDATA),
    .raddr   (raddr),
    .dout    (dout)
  );

  // Read data is valid during the data phase
  assign HRDATA = dout;

  // SRAM never errors
  assign HRESP  = ahb_pkg::HRESP_OKAY;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // The stall lasts one cycle, so the master must have held the read
  a_single_wait : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !HREADYOUT |=> HREADYOUT
  );

  // Word transfers from the master arrive word-aligned
  a_word_aligned : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (HSEL && HREADY && trans_valid && (HSIZE == ahb_pkg::HSIZE_WORD))
      |-> (HADDR[sram_pkg::LANE_BITS-1:0] == '0)
  );

endmodule

/* logic/ram_1r1w.sv */
`timescale 1ns/1ns

module ram_1r1w #(
  parameter int ABITS = 8
) (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic [ABITS-1:0]    waddr,
  input  logic                we,
  input  sram_pkg::byte_en_t  be,
  input  ahb_pkg::hdata_t     din,
  input  logic [ABITS-1:0]    raddr,
  output ahb_pkg::hdata_t     dout
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  ahb_pkg::hdata_t mem [2**ABITS];

  // Write port, one byte lane at a time
  always_ff @(posedge HCLK) begin
    if (we) begin
      for (int i = 0; i < sram_pkg::BYTE_LANES; i++) begin
        if (be[i]) begin
          mem[waddr][8*i +: 8] <= din[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Registered read
  // A full-word write to the same address bypasses the array
  // Partial writes are not merged here, the slave stalls for those
  always_ff @(posedge HCLK) begin
    if (we && (&be) && (waddr == raddr)) begin
      dout <= din;
    end else begin
      dout <= mem[raddr];
    end
  end

  // Byte enables come from the bus slave decode, an empty mask means a lost write
  a_no_empty_be : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    we |-> (|be)
  );

endmodule

/* logic/sram_pkg.sv */
package sram_pkg;

  ////////////////////////////////////////
  // Memory word layout
  ////////////////////////////////////////

  // Byte lanes in one 32-bit memory word
  localparam int BYTE_LANES = 4;

  // Address bits that select a lane inside a word
  localparam int LANE_BITS = $clog2(BYTE_LANES);

  // One write enable per byte lane
  typedef logic [BYTE_LANES-1:0] byte_en_t;

  ////////////////////////////////////////
  // Default slave
  ////////////////////////////////////////

  // Idle, or in the second cycle of the ERROR response
  typedef enum logic {
    DFLT_IDLE = 1'b0,
    DFLT_ERR2 = 1'b1
  } dflt_state_t;

endpackage

/* logic/ahb_pkg.sv */
package ahb_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int HADDR_WIDTH = 32;
  localparam int HDATA_WIDTH = 32;

  // Byte address and data word as seen on the bus
  typedef logic [HADDR_WIDTH-1:0] haddr_t;
  typedef logic [HDATA_WIDTH-1:0] hdata_t;

  ////////////////////////////////////////
  // Transfer encodings
  ////////////////////////////////////////

  // Transfer size, only sizes up to one word are used on a 32-bit bus
  typedef logic [2:0] hsize_t;

  localparam hsize_t HSIZE_BYTE  = 3'b000;
  localparam hsize_t HSIZE_HWORD = 3'b001;
  localparam hsize_t HSIZE_WORD  = 3'b010;

  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Slave response, AHB-Lite drops RETRY and SPLIT
  typedef logic hresp_t;

  localparam hresp_t HRESP_OKAY  = 1'b0;
  localparam hresp_t HRESP_ERROR = 1'b1;

endpackage
